// ==== lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// ========================================
// Buffering and link timing
// ========================================

`define LCD_FIFO_DEPTH 8 // Byte FIFO entries, also initial credits
`define LCD_SPI_HALF 2 // Clocks per SCK half period

// ========================================
// ILI9341 command codes
// ========================================

`define LCD_CMD_CASET 8'h2A // Column address set
`define LCD_CMD_PASET 8'h2B // Page address set
`define LCD_CMD_RAMWR 8'h2C // Memory write

`endif

// ==== lcd_pkg.sv ====
`default_nettype none

`include "lcd_settings.svh"

package lcd_pkg;

	typedef logic [15:0] coord_t; // Pixel coordinate
	typedef logic [15:0] pixel_t; // RGB565 colour
	typedef logic [7:0] lcd_byte_t; // One SPI byte
	typedef logic [16:0] pix_count_t; // Up to 320 x 240 pixels

	// Holds 0 up to the full FIFO depth
	typedef logic [$clog2(`LCD_FIFO_DEPTH + 1) - 1:0] credit_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_CASET,
		SEQ_PASET,
		SEQ_RAMWR,
		SEQ_PIXELS,
		SEQ_WAIT_DONE
	} seq_state_t;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SETUP,
		SPI_HIGH,
		SPI_DONE
	} spi_state_t;

endpackage

`default_nettype wire

// ==== lcd_fill_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_fill_sequencer import lcd_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_start,
	input wire coord_t i_x0,
	input wire coord_t i_y0,
	input wire coord_t i_x1,
	input wire coord_t i_y1,
	input wire pixel_t i_color,
	input wire logic i_credit_return,
	input wire logic i_frame_done,
	output logic o_busy,
	output logic o_push,
	output lcd_byte_t o_data,
	output logic o_rs,
	output logic o_last
);

	seq_state_t state;
	credit_t credits;
	logic [2:0] byte_idx; // Position within a command group
	pix_count_t pix_left;

	coord_t x0_q, y0_q, x1_q, y1_q;
	pixel_t color_q;

	coord_t span_x, span_y;
	logic [31:0] area;
	pix_count_t pix_total;

	// Command byte followed by two coordinates, high byte first
	function automatic lcd_byte_t addr_byte(input logic [2:0] idx, input lcd_byte_t cmd,
		input coord_t c_lo, input coord_t c_hi);
		case (idx)
			3'd0: addr_byte = cmd;
			3'd1: addr_byte = c_lo[15:8];
			3'd2: addr_byte = c_lo[7:0];
			3'd3: addr_byte = c_hi[15:8];
			default: addr_byte = c_hi[7:0];
		endcase
	endfunction

	assign span_x = x1_q - x0_q + 16'd1;
	assign span_y = y1_q - y0_q + 16'd1;
	assign area = span_x * span_y;
	assign pix_total = area[16:0];

	// ========================================
	// Byte emission, gated by credits
	// ========================================

	always_comb begin
		o_data = '0;
		o_rs = 1'b1;
		case (state)
			SEQ_CASET: begin
				o_data = addr_byte(byte_idx, `LCD_CMD_CASET, x0_q, x1_q);
				o_rs = (byte_idx != 3'd0);
			end
			SEQ_PASET: begin
				o_data = addr_byte(byte_idx, `LCD_CMD_PASET, y0_q, y1_q);
				o_rs = (byte_idx != 3'd0);
			end
			SEQ_RAMWR: begin
				o_data = `LCD_CMD_RAMWR;
				o_rs = 1'b0;
			end
			SEQ_PIXELS: o_data = byte_idx[0] ? color_q[7:0] : color_q[15:8];
			default: o_data = '0;
		endcase
	end

	assign o_push = (state inside {SEQ_CASET, SEQ_PASET, SEQ_RAMWR, SEQ_PIXELS})
		&& (credits != '0);
	assign o_last = (state == SEQ_PIXELS) && byte_idx[0] && (pix_left == pix_count_t'(1));
	assign o_busy = (state != SEQ_IDLE);

	always_ff @(posedge i_clock) begin
		if (state == SEQ_IDLE && i_start) begin // Latch rectangle and colour
			x0_q <= i_x0;
			y0_q <= i_y0;
			x1_q <= i_x1;
			y1_q <= i_y1;
			color_q <= i_color;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= SEQ_IDLE;
			credits <= credit_t'(`LCD_FIFO_DEPTH);
			byte_idx <= '0;
			pix_left <= '0;
		end else begin
			case ({o_push, i_credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // Push and return cancel
			endcase

			case (state)
				SEQ_IDLE: begin
					byte_idx <= '0;
					if (i_start)
						state <= SEQ_CASET;
				end
				SEQ_CASET: begin
					if (o_push) begin
						byte_idx <= (byte_idx == 3'd4) ? 3'd0 : byte_idx + 3'd1;
						if (byte_idx == 3'd4)
							state <= SEQ_PASET;
					end
				end
				SEQ_PASET: begin
					if (o_push) begin
						byte_idx <= (byte_idx == 3'd4) ? 3'd0 : byte_idx + 3'd1;
						if (byte_idx == 3'd4)
							state <= SEQ_RAMWR;
					end
				end
				SEQ_RAMWR: begin
					if (o_push) begin
						pix_left <= pix_total;
						byte_idx <= '0;
						state <= SEQ_PIXELS;
					end
				end
				SEQ_PIXELS: begin
					if (o_push) begin
						byte_idx <= {2'b00, ~byte_idx[0]}; // Toggle high/low colour byte
						if (byte_idx[0]) begin
							pix_left <= pix_left - 1'b1;
							if (o_last)
								state <= SEQ_WAIT_DONE;
						end
					end
				end
				SEQ_WAIT_DONE: begin
					if (i_frame_done)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lcd_byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_byte_fifo import lcd_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_push,
	input wire lcd_byte_t i_data,
	input wire logic i_rs,
	input wire logic i_last,
	input wire logic i_pop,
	output logic o_valid,
	output lcd_byte_t o_data,
	output logic o_rs,
	output logic o_last,
	output logic o_credit_return
);

	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [9:0] mem [DEPTH]; // {last, rs, data}
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	credit_t count;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop = i_pop && o_valid;
	assign o_valid = (count != '0);
	assign {o_last, o_rs, o_data} = mem[rd_ptr];
	assign o_credit_return = do_pop; // One credit back per byte taken

	always_ff @(posedge i_clock) begin
		if (i_push)
			mem[wr_ptr] <= {i_last, i_rs, i_data}; // Credits guarantee a free slot
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({i_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lcd_spi_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_spi_serializer import lcd_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_valid,
	input wire lcd_byte_t i_data,
	input wire logic i_rs,
	input wire logic i_last,
	output logic o_pop,
	output logic o_frame_done,
	output logic o_lcd_cs,
	output logic o_lcd_rs,
	output logic o_lcd_mosi,
	output logic o_lcd_sck
);

	localparam int HALF = `LCD_SPI_HALF;

	spi_state_t state;
	logic [15:0] dly; // Half-period delay counter
	logic [2:0] bit_cnt; // Bits left after the current one
	lcd_byte_t shreg;
	logic last_q;
	logic half_end;

	assign half_end = (dly == '0);
	assign o_pop = (state == SPI_IDLE) && i_valid; // Load cycle

	// ========================================
	// Payload shift register
	// ========================================

	always_ff @(posedge i_clock) begin
		if (o_pop) begin
			shreg <= i_data;
			last_q <= i_last;
		end else if (state == SPI_HIGH && half_end) begin
			shreg <= {shreg[6:0], 1'b0}; // MSB first
		end
	end

	// ========================================
	// Mode-0 bit timing and framing
	// ========================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= SPI_IDLE;
			dly <= '0;
			bit_cnt <= '0;
			o_lcd_cs <= 1'b1; // Deselected
			o_lcd_sck <= 1'b0;
			o_lcd_rs <= 1'b0;
			o_lcd_mosi <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			case (state)
				SPI_IDLE: begin
					o_lcd_sck <= 1'b0;
					if (i_valid) begin
						o_lcd_cs <= 1'b0; // Stays low until frame end
						o_lcd_rs <= i_rs;
						o_lcd_mosi <= i_data[7];
						dly <= 16'(HALF - 1);
						bit_cnt <= 3'd7;
						state <= SPI_SETUP;
					end
				end
				SPI_SETUP: begin
					dly <= dly - 1'b1;
					if (half_end) begin
						o_lcd_sck <= 1'b1; // Slave samples here
						dly <= 16'(HALF - 1);
						state <= SPI_HIGH;
					end
				end
				SPI_HIGH: begin
					dly <= dly - 1'b1;
					if (half_end) begin
						o_lcd_sck <= 1'b0;
						dly <= 16'(HALF - 1);
						if (bit_cnt == 3'd0) begin
							state <= last_q ? SPI_DONE : SPI_IDLE;
						end else begin
							bit_cnt <= bit_cnt - 1'b1;
							o_lcd_mosi <= shreg[6]; // Next bit on falling SCK
							state <= SPI_SETUP;
						end
					end
				end
				SPI_DONE: begin
					o_lcd_cs <= 1'b1;
					o_frame_done <= 1'b1;
					state <= SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lcd_spi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_top import lcd_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_start,
	input wire coord_t i_x0,
	input wire coord_t i_y0,
	input wire coord_t i_x1,
	input wire coord_t i_y1,
	input wire pixel_t i_color,
	output logic o_busy,
	output logic o_lcd_rst,
	output logic o_lcd_cs,
	output logic o_lcd_rs,
	output logic o_lcd_mosi,
	output logic o_lcd_sck
);

	logic push, push_rs, push_last;
	lcd_byte_t push_data;
	logic credit_return;
	logic head_valid, head_rs, head_last, pop;
	lcd_byte_t head_data;
	logic frame_done;

	assign o_lcd_rst = ~i_rst; // Panel reset is active low

	lcd_fill_sequencer u_seq (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_start(i_start),
		.i_x0(i_x0),
		.i_y0(i_y0),
		.i_x1(i_x1),
		.i_y1(i_y1),
		.i_color(i_color),
		.i_credit_return(credit_return),
		.i_frame_done(frame_done),
		.o_busy(o_busy),
		.o_push(push),
		.o_data(push_data),
		.o_rs(push_rs),
		.o_last(push_last)
	);

	lcd_byte_fifo u_fifo (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_push(push),
		.i_data(push_data),
		.i_rs(push_rs),
		.i_last(push_last),
		.i_pop(pop),
		.o_valid(head_valid),
		.o_data(head_data),
		.o_rs(head_rs),
		.o_last(head_last),
		.o_credit_return(credit_return)
	);

	lcd_spi_serializer u_ser (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_valid(head_valid),
		.i_data(head_data),
		.i_rs(head_rs),
		.i_last(head_last),
		.o_pop(pop),
		.o_frame_done(frame_done),
		.o_lcd_cs(o_lcd_cs),
		.o_lcd_rs(o_lcd_rs),
		.o_lcd_mosi(o_lcd_mosi),
		.o_lcd_sck(o_lcd_sck)
	);

endmodule

`default_nettype wire

// ==== lcd_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_clock_gen (
	output logic o_clock,
	output logic o_rst
);

	initial begin
		o_clock = 1'b0;
		forever #10 o_clock = ~o_clock; // 20 ns period
	end

	initial begin
		o_rst = 1'b1;
		repeat (5) @(posedge o_clock);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== lcd_spi_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_props (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_busy,
	input wire logic i_lcd_rst,
	input wire logic i_lcd_cs,
	input wire logic i_lcd_sck,
	input wire logic i_lcd_mosi
);

	// ========================================
	// Framing and SPI mode 0
	// ========================================

	sck_in_frame: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_lcd_sck != $past(i_lcd_sck)) |-> !i_lcd_cs)
		else $error("SCK toggled while chip select was high");

	cs_with_sck_low: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_lcd_cs != $past(i_lcd_cs)) |-> (!i_lcd_sck && !$past(i_lcd_sck)))
		else $error("Chip select changed while SCK was high");

	mosi_stable_high: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_lcd_sck && $past(i_lcd_sck)) |-> (i_lcd_mosi == $past(i_lcd_mosi)))
		else $error("MOSI changed during the SCK high phase");

	busy_after_cs: assert property (@(posedge i_clock) disable iff (i_rst)
		(!i_busy && $past(i_busy)) |-> i_lcd_cs)
		else $error("Busy fell before chip select went high");

	// Reset values at the pins
	panel_reset: assert property (@(posedge i_clock) i_rst |-> !i_lcd_rst)
		else $error("LCD reset pin high during reset");

	idle_after_reset: assert property (@(posedge i_clock) i_rst |=> (i_lcd_cs && !i_lcd_sck))
		else $error("Chip select or SCK not idle after reset");

endmodule

bind lcd_spi_top lcd_spi_props u_props (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_busy(o_busy),
	.i_lcd_rst(o_lcd_rst),
	.i_lcd_cs(o_lcd_cs),
	.i_lcd_sck(o_lcd_sck),
	.i_lcd_mosi(o_lcd_mosi)
);

`default_nettype wire

// ==== lcd_spi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_spi_tb import lcd_pkg::*; ();

	localparam int PIXELS = 1 + 6 + 12 + 4; // Sum over the four fills
	localparam int TOTAL_BYTES = 4 * 11 + 2 * PIXELS;
	localparam int CYCLE_LIMIT = TOTAL_BYTES * (16 * `LCD_SPI_HALF + 4) + 200;

	logic clock, rst, start;
	coord_t x0, y0, x1, y1;
	pixel_t color, rand_color;
	logic busy, lcd_rst, lcd_cs, lcd_rs, lcd_mosi, lcd_sck;

	logic [8:0] exp_q[$]; // {rs, byte}
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int frame_bytes = 0;
	integer seed;
	logic sck_d = 1'b0;
	logic [2:0] bit_cnt = '0;
	logic [6:0] shift = '0;

	lcd_clock_gen u_clk (.o_clock(clock), .o_rst(rst));

	lcd_spi_top dut0 (
		.i_clock(clock), .i_rst(rst), .i_start(start),
		.i_x0(x0), .i_y0(y0), .i_x1(x1), .i_y1(y1), .i_color(color),
		.o_busy(busy), .o_lcd_rst(lcd_rst), .o_lcd_cs(lcd_cs),
		.o_lcd_rs(lcd_rs), .o_lcd_mosi(lcd_mosi), .o_lcd_sck(lcd_sck)
	);

	// ========================================
	// Expected stream and SPI decoder
	// ========================================

	task automatic queue_frame(input coord_t ax0, ay0, ax1, ay1, input pixel_t c);
		int n;
		n = (int'(ax1) - int'(ax0) + 1) * (int'(ay1) - int'(ay0) + 1);
		exp_q.push_back({1'b0, 8'h2A});
		exp_q.push_back({1'b1, ax0[15:8]});
		exp_q.push_back({1'b1, ax0[7:0]});
		exp_q.push_back({1'b1, ax1[15:8]});
		exp_q.push_back({1'b1, ax1[7:0]});
		exp_q.push_back({1'b0, 8'h2B});
		exp_q.push_back({1'b1, ay0[15:8]});
		exp_q.push_back({1'b1, ay0[7:0]});
		exp_q.push_back({1'b1, ay1[15:8]});
		exp_q.push_back({1'b1, ay1[7:0]});
		exp_q.push_back({1'b0, 8'h2C});
		for (int i = 0; i < n; i++) begin
			exp_q.push_back({1'b1, c[15:8]});
			exp_q.push_back({1'b1, c[7:0]});
		end
	endtask

	task automatic check_byte(input lcd_byte_t got, input logic got_rs);
		logic [8:0] want;
		frame_bytes++;
		assert (exp_q.size() != 0) else begin
			$display("Byte %h arrived on the SPI bus with nothing expected", got);
			other_errors++;
		end
		if (exp_q.size() != 0) begin
			want = exp_q.pop_front();
			assert (got == want[7:0]) else begin
				$display("Fail o_lcd_mosi byte: expected %h, got %h", want[7:0], got);
				value_errors++;
			end
			assert (got_rs == want[8]) else begin
				$display("Fail o_lcd_rs: expected %h, got %h", want[8], got_rs);
				value_errors++;
			end
		end
	endtask

	always @(posedge clock) begin
		sck_d <= lcd_sck;
		if (lcd_cs === 1'b1) begin
			bit_cnt <= '0; // Realign on each frame
		end else if (lcd_sck && !sck_d) begin // SCK rose in the last cycle
			shift <= {shift[5:0], lcd_mosi};
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
				check_byte({shift, lcd_mosi}, lcd_rs);
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, a frame never finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	task automatic run_fill(input coord_t ax0, ay0, ax1, ay1, input pixel_t c, input bit poke);
		int n_bytes;
		int cyc;
		n_bytes = 11 + 2 * (int'(ax1) - int'(ax0) + 1) * (int'(ay1) - int'(ay0) + 1);
		queue_frame(ax0, ay0, ax1, ay1, c);
		frame_bytes = 0;
		@(posedge clock);
		start <= 1'b1;
		x0 <= ax0;
		y0 <= ay0;
		x1 <= ax1;
		y1 <= ay1;
		color <= c;
		@(posedge clock);
		start <= 1'b0;
		cyc = 0;
		@(posedge clock);
		assert (busy) else begin
			$display("Busy did not rise after an accepted start");
			other_errors++;
		end
		while (busy) begin
			if (poke && cyc == 40) begin
				start <= 1'b1; // Must be ignored mid-frame
				x1 <= ax1 + 16'd5;
			end else begin
				start <= 1'b0;
			end
			cyc++;
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		assert (frame_bytes == n_bytes) else begin
			$display("Fail byte count: expected %h, got %h", n_bytes, frame_bytes);
			value_errors++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Frame ended with %0d expected bytes never sent", exp_q.size());
			other_errors++;
		end
		assert (!busy && lcd_cs) else begin
			$display("DUT did not return to idle after the frame");
			other_errors++;
		end
	endtask

	initial begin
		start = 1'b0;
		x0 = '0;
		y0 = '0;
		x1 = '0;
		y1 = '0;
		color = '0;
		seed = 53;
		@(posedge clock);
		while (rst) @(posedge clock);
		run_fill(16'd10, 16'd20, 16'd10, 16'd20, 16'hF800, 1'b0); // 1 x 1
		run_fill(16'd0, 16'd0, 16'd2, 16'd1, 16'h07E0, 1'b0); // 3 x 2
		rand_color = pixel_t'($random(seed));
		run_fill(16'd300, 16'd236, 16'd303, 16'd238, rand_color, 1'b0); // 4 x 3
		run_fill(16'd5, 16'd7, 16'd6, 16'd8, 16'h001F, 1'b1); // 2 x 2, start while busy
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
lcd_pkg.sv
lcd_fill_sequencer.sv
lcd_byte_fifo.sv
lcd_spi_serializer.sv
lcd_spi_top.sv
lcd_clock_gen.sv
lcd_spi_props.sv
lcd_spi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module lcd_spi_tb \
	-o lcd_spi_sim \
	&& ./obj_dir/lcd_spi_sim > sim.log 2>&1 \
	|| echo "Build or simulation stopped early" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
